// File: filelist.f
verilog/afifo_pkg.sv
verilog/gray_ptr_counter.sv
verilog/gray_sync.sv
verilog/afifo_asym_ram.sv
verilog/afifo_async.sv
verilog/afifo_top.sv
testbench/afifo_assertions.sv
testbench/afifo_tb.sv

// File: Makefile
# Verilator build and run for the dual-clock asymmetric FIFO

VERILATOR   ?= verilator
TOP         ?= afifo_tb
SYNC_STAGES ?= 2
OBJ_DIR     ?= obj_dir
FILELIST    ?= filelist.f
PASS_MSG    := Simulation finished: PASS

VFLAGS ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSYNC_STAGES=$(SYNC_STAGES) --Mdir $(OBJ_DIR)

# pass only when the simulation prints the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP) \
		-GSYNC_STAGES=$(SYNC_STAGES)

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/afifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module afifo_tb
  import afifo_pkg::*;
#(
  parameter int SYNC_STAGES = 2
);

  localparam int W_PERIOD = 100;
  localparam int R_PERIOD = 130;
  localparam int N_PHASES = 8;

  logic          w_clk;
  logic          r_clk;
  logic          rst_n;
  logic          w_en;
  wdata_t        w_data;
  afifo_status_t w_status;
  logic          r_en;
  rdata_t        r_data;
  afifo_status_t r_status;

  // stimulus table, one row per phase, exp_len -1 means any length
  string phase_name [N_PHASES] = '{"order", "drain", "fill", "drain", "empty_rd",
                                   "random_a", "random_b", "drain"};
  int    wr_cnt     [N_PHASES] = '{4, 0, 8, 0, 0, 60, 80, 0};
  int    rd_cnt     [N_PHASES] = '{0, 24, 0, 24, 6, 200, 120, 40};
  int    wr_pct     [N_PHASES] = '{100, 0, 100, 0, 0, 50, 90, 0};
  int    rd_pct     [N_PHASES] = '{0, 100, 0, 100, 100, 70, 40, 100};
  int    exp_len    [N_PHASES] = '{16, 0, 16, 0, 0, -1, -1, 0};

  rdata_t model_q [$];
  integer w_seed = 63509;
  integer r_seed = 63509;

  afifo_top #(
    .SYNC_STAGES (SYNC_STAGES)
  ) dut_i (
    .rst_n_i    (rst_n),
    .w_clk_i    (w_clk),
    .w_en_i     (w_en),
    .w_data_i   (w_data),
    .w_status_o (w_status),
    .r_clk_i    (r_clk),
    .r_en_i     (r_en),
    .r_data_o   (r_data),
    .r_status_o (r_status)
  );

  initial begin
    w_clk = 1'b0;
    forever #(W_PERIOD / 2) w_clk = ~w_clk;
  end

  initial begin
    r_clk = 1'b0;
    forever #(R_PERIOD / 2) r_clk = ~r_clk;
  end

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s: got 0x%0h, expected 0x%0h", $time, msg, actual, expected);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // statuses only move on their own clock, so +5 ns sees the value for the next edge
  task automatic run_writes(input int count, input int pct);
    int roll;
    for (int i = 0; i < count; i++) begin
      @(posedge w_clk);
      #5;
      check_equal(32'(w_status.level > level_t'(AFIFO_DEPTH)), 32'd0, "write level range");
      roll = $unsigned($random(w_seed)) % 100;
      w_en = (roll < pct);
      w_data = $random(w_seed);
      if (w_en && !w_status.full) begin
        for (int b = 0; b < AFIFO_RATIO; b++) begin
          model_q.push_back(w_data[b*AFIFO_R_DATA_W +: AFIFO_R_DATA_W]);
        end
      end
    end
    @(posedge w_clk);
    #5;
    w_en = 1'b0;
  endtask

  task automatic run_reads(input int count, input int pct);
    int     roll;
    bit     pending;
    bit     held;
    rdata_t exp_byte;
    rdata_t last_byte;
    pending = 1'b0;
    held = 1'b0;
    // one extra cycle to see the data of the last accepted read
    for (int i = 0; i <= count; i++) begin
      @(posedge r_clk);
      #5;
      if (pending) begin
        check_equal(32'(r_data), 32'(exp_byte), "read byte vs model");
      end
      if (held) begin
        check_equal(32'(r_data), 32'(last_byte), "data held on empty read");
      end
      check_equal(32'(r_status.level > level_t'(AFIFO_DEPTH)), 32'd0, "read level range");
      pending = 1'b0;
      held = 1'b0;
      if (i < count) begin
        roll = $unsigned($random(r_seed)) % 100;
        r_en = (roll < pct);
        if (r_en && !r_status.empty) begin
          check_equal(32'(model_q.size() > 0), 32'd1, "model holds a byte");
          exp_byte = model_q.pop_front();
          pending = 1'b1;
        end else if (r_en) begin
          check_equal(32'(r_status.level), 32'd0, "level on empty read");
          last_byte = r_data;
          held = 1'b1;
        end
      end else begin
        r_en = 1'b0;
      end
    end
  endtask

  // both sides idle long enough for the far pointers to settle
  task automatic check_settled(input int idx);
    int qlen;
    repeat (SYNC_STAGES + 2) @(posedge r_clk);
    #5;
    qlen = model_q.size();
    if (exp_len[idx] >= 0) begin
      check_equal(32'(qlen), 32'(exp_len[idx]), "bytes held after phase");
    end
    check_equal(32'(w_status.level), 32'(qlen), "write level vs model");
    check_equal(32'(r_status.level), 32'(qlen), "read level vs model");
    check_equal(32'(w_status.full), 32'(qlen > AFIFO_DEPTH - AFIFO_RATIO), "write full");
    check_equal(32'(w_status.empty), 32'(qlen < AFIFO_RATIO), "write empty");
    check_equal(32'(r_status.full), 32'(qlen == AFIFO_DEPTH), "read full");
    check_equal(32'(r_status.empty), 32'(qlen == 0), "read empty");
  endtask

  initial begin
    rst_n = 1'b0;
    w_en = 1'b0;
    w_data = '0;
    r_en = 1'b0;
    repeat (3) @(posedge r_clk);
    #5;
    rst_n = 1'b1;

    check_equal(32'(w_status), 32'(afifo_status_t'{1'b1, 1'b0, '0}), "write status after reset");
    check_equal(32'(r_status), 32'(afifo_status_t'{1'b1, 1'b0, '0}), "read status after reset");
    check_equal(32'(r_data), 32'd0, "read data after reset");

    for (int p = 0; p < N_PHASES; p++) begin
      $display("phase %0d: %s", p, phase_name[p]);
      fork
        run_writes(wr_cnt[p], wr_pct[p]);
        run_reads(rd_cnt[p], rd_pct[p]);
      join
      check_settled(p);
    end

    $display("Simulation finished: PASS");
    $finish;
  end

  // watchdog sized from the table
  initial begin
    longint timeout_ns;
    timeout_ns = 0;
    for (int p = 0; p < N_PHASES; p++) begin
      timeout_ns += wr_cnt[p] + rd_cnt[p];
    end
    timeout_ns = timeout_ns * R_PERIOD * 4 + 10000;
    #(timeout_ns);
    $display("timeout: the test did not finish within %0d ns", timeout_ns);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: testbench/afifo_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module afifo_assertions
  import afifo_pkg::*;
(
  input logic                    w_clk_i,
  input logic                    r_clk_i,
  input logic                    rst_n_i,
  input afifo_status_t           w_status_i,
  input afifo_status_t           r_status_i,
  input logic [AFIFO_W_ADDR_W:0] w_ptr_i,
  input logic [AFIFO_ADDR_W:0]   r_ptr_i
);

  // a stale far pointer makes the write side over-count and the read side under-count
  w_r_level_order_a: assert property (@(posedge w_clk_i) disable iff (!rst_n_i)
    w_status_i.level >= r_status_i.level)
    else $error("write level below read level");

  w_level_max_a: assert property (@(posedge w_clk_i) disable iff (!rst_n_i)
    w_status_i.level <= level_t'(AFIFO_DEPTH))
    else $error("write level above depth");

  r_level_max_a: assert property (@(posedge r_clk_i) disable iff (!rst_n_i)
    r_status_i.level <= level_t'(AFIFO_DEPTH))
    else $error("read level above depth");

  // a full write side must drop the request
  w_ptr_hold_a: assert property (@(posedge w_clk_i) disable iff (!rst_n_i)
    w_status_i.full |=> $stable(w_ptr_i))
    else $error("write pointer moved while full");

  r_ptr_hold_a: assert property (@(posedge r_clk_i) disable iff (!rst_n_i)
    r_status_i.empty |=> $stable(r_ptr_i))
    else $error("read pointer moved while empty");

  w_reset_empty_a: assert property (@(posedge w_clk_i) !rst_n_i |=> w_status_i.empty)
    else $error("write side not empty after reset");

  r_reset_empty_a: assert property (@(posedge r_clk_i) !rst_n_i |=> r_status_i.empty)
    else $error("read side not empty after reset");

endmodule

bind afifo_async afifo_assertions afifo_assertions0 (
  .w_clk_i    (w_clk_i),
  .r_clk_i    (r_clk_i),
  .rst_n_i    (rst_n_i),
  .w_status_i (w_status_o),
  .r_status_i (r_status_o),
  .w_ptr_i    (w_wbin),
  .r_ptr_i    (r_rbin)
);

`default_nettype wire

// File: verilog/afifo_top.sv
`timescale 1ns/1ps
`default_nettype none

module afifo_top
  import afifo_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic          rst_n_i,

  // write domain
  input  logic          w_clk_i,
  input  logic          w_en_i,
  input  wdata_t        w_data_i,
  output afifo_status_t w_status_o,

  // read domain
  input  logic          r_clk_i,
  input  logic          r_en_i,
  output rdata_t        r_data_o,
  output afifo_status_t r_status_o
);

  logic   mem_w_en;
  waddr_t mem_w_addr;
  wdata_t mem_w_data;
  logic   mem_r_en;
  raddr_t mem_r_addr;

  afifo_async #(
    .SYNC_STAGES (SYNC_STAGES)
  ) afifo_async0 (
    .w_clk_i      (w_clk_i),
    .r_clk_i      (r_clk_i),
    .rst_n_i      (rst_n_i),
    .w_en_i       (w_en_i),
    .w_data_i     (w_data_i),
    .w_status_o   (w_status_o),
    .r_en_i       (r_en_i),
    .r_status_o   (r_status_o),
    .mem_w_en_o   (mem_w_en),
    .mem_w_addr_o (mem_w_addr),
    .mem_w_data_o (mem_w_data),
    .mem_r_en_o   (mem_r_en),
    .mem_r_addr_o (mem_r_addr)
  );

  // strobes arrive already gated by the flags
  afifo_asym_ram afifo_asym_ram0 (
    .w_clk_i  (w_clk_i),
    .w_en_i   (mem_w_en),
    .w_addr_i (mem_w_addr),
    .w_data_i (mem_w_data),
    .r_clk_i  (r_clk_i),
    .rst_n_i  (rst_n_i),
    .r_en_i   (mem_r_en),
    .r_addr_i (mem_r_addr),
    .r_data_o (r_data_o)
  );

endmodule

`default_nettype wire

// File: verilog/afifo_async.sv
`timescale 1ns/1ps
`default_nettype none

module afifo_async
  import afifo_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic          w_clk_i,
  input  logic          r_clk_i,
  input  logic          rst_n_i,

  // write domain
  input  logic          w_en_i,
  input  wdata_t        w_data_i,
  output afifo_status_t w_status_o,

  // read domain
  input  logic          r_en_i,
  output afifo_status_t r_status_o,

  // memory side
  output logic          mem_w_en_o,
  output waddr_t        mem_w_addr_o,
  output wdata_t        mem_w_data_o,
  output logic          mem_r_en_o,
  output raddr_t        mem_r_addr_o
);

  // word pointer on the write side, byte pointer on the read side,
  // both with a wrap bit on top
  localparam int W_PTR_W = AFIFO_W_ADDR_W + 1;
  localparam int R_PTR_W = AFIFO_ADDR_W + 1;

  // write domain signals
  logic [W_PTR_W-1:0] w_wbin;
  logic [W_PTR_W-1:0] w_wgray;
  logic [R_PTR_W-1:0] w_rgray_sync;
  logic [R_PTR_W-1:0] w_rbin_sync;
  level_t             w_level;
  logic               w_full;
  logic               w_empty;
  logic               w_acc;

  // read domain signals
  logic [R_PTR_W-1:0] r_rbin;
  logic [R_PTR_W-1:0] r_rgray;
  logic [W_PTR_W-1:0] r_wgray_sync;
  logic [W_PTR_W-1:0] r_wbin_sync;
  level_t             r_level;
  logic               r_full;
  logic               r_empty;
  logic               r_acc;

  // accept only what the local flags allow
  assign w_acc = w_en_i & ~w_full;
  assign r_acc = r_en_i & ~r_empty;

  gray_ptr_counter #(
    .PTR_W (W_PTR_W)
  ) w_ptr_cnt0 (
    .clk_i   (w_clk_i),
    .rst_n_i (rst_n_i),
    .en_i    (w_acc),
    .bin_o   (w_wbin),
    .gray_o  (w_wgray)
  );

  gray_ptr_counter #(
    .PTR_W (R_PTR_W)
  ) r_ptr_cnt0 (
    .clk_i   (r_clk_i),
    .rst_n_i (rst_n_i),
    .en_i    (r_acc),
    .bin_o   (r_rbin),
    .gray_o  (r_rgray)
  );

  // write pointer into the read domain
  gray_sync #(
    .PTR_W       (W_PTR_W),
    .SYNC_STAGES (SYNC_STAGES)
  ) w2r_sync0 (
    .clk_i   (r_clk_i),
    .rst_n_i (rst_n_i),
    .gray_i  (w_wgray),
    .gray_o  (r_wgray_sync)
  );

  // read pointer into the write domain
  gray_sync #(
    .PTR_W       (R_PTR_W),
    .SYNC_STAGES (SYNC_STAGES)
  ) r2w_sync0 (
    .clk_i   (w_clk_i),
    .rst_n_i (rst_n_i),
    .gray_i  (r_rgray),
    .gray_o  (w_rgray_sync)
  );

  // gray to binary: bit i is the xor of gray bits i and above
  always_comb begin
    for (int i = 0; i < R_PTR_W; i++) begin
      w_rbin_sync[i] = ^(w_rgray_sync >> i);
    end
  end

  always_comb begin
    for (int i = 0; i < W_PTR_W; i++) begin
      r_wbin_sync[i] = ^(r_wgray_sync >> i);
    end
  end

  // levels in bytes, the word pointer scaled by the width ratio
  assign w_level = (level_t'(w_wbin) << AFIFO_RATIO_LOG) - level_t'(w_rbin_sync);
  assign r_level = (level_t'(r_wbin_sync) << AFIFO_RATIO_LOG) - level_t'(r_rbin);

  // write side thinks in words: full when no room for another word
  assign w_full  = w_level > level_t'(AFIFO_DEPTH - AFIFO_RATIO);
  assign w_empty = w_level < level_t'(AFIFO_RATIO);

  // read side thinks in bytes
  assign r_empty = r_level == '0;
  assign r_full  = r_level == level_t'(AFIFO_DEPTH);

  always_comb begin
    w_status_o.empty = w_empty;
    w_status_o.full  = w_full;
    w_status_o.level = w_level;
  end

  always_comb begin
    r_status_o.empty = r_empty;
    r_status_o.full  = r_full;
    r_status_o.level = r_level;
  end

  // pointer bits below the wrap bit address the memory
  assign mem_w_en_o   = w_acc;
  assign mem_w_addr_o = w_wbin[AFIFO_W_ADDR_W-1:0];
  assign mem_w_data_o = w_data_i;
  assign mem_r_en_o   = r_acc;
  assign mem_r_addr_o = r_rbin[AFIFO_ADDR_W-1:0];

endmodule

`default_nettype wire

// File: verilog/afifo_asym_ram.sv
`timescale 1ns/1ps
`default_nettype none

module afifo_asym_ram
  import afifo_pkg::*;
(
  // write port, one whole word per strobe
  input  logic   w_clk_i,
  input  logic   w_en_i,
  input  waddr_t w_addr_i,
  input  wdata_t w_data_i,

  // read port, one byte per strobe
  input  logic   r_clk_i,
  input  logic   rst_n_i,
  input  logic   r_en_i,
  input  raddr_t r_addr_i,
  output rdata_t r_data_o
);

  localparam int N_WORDS = AFIFO_DEPTH / AFIFO_RATIO;

  wdata_t mem_q [N_WORDS];

  waddr_t                     r_word_sel;
  logic [AFIFO_RATIO_LOG-1:0] r_lane_sel;
  wdata_t                     r_word;
  rdata_t                     r_byte;
  rdata_t                     r_data_q;

  always_ff @(posedge w_clk_i) begin
    if (w_en_i) begin
      mem_q[w_addr_i] <= w_data_i;
    end
  end

  // upper bits pick the word, lower bits pick the byte lane
  assign r_word_sel = r_addr_i[AFIFO_ADDR_W-1:AFIFO_RATIO_LOG];
  assign r_lane_sel = r_addr_i[AFIFO_RATIO_LOG-1:0];
  assign r_word     = mem_q[r_word_sel];

  // lane 0 is the least significant byte, so words leave LSB first
  assign r_byte = r_word[r_lane_sel*AFIFO_R_DATA_W +: AFIFO_R_DATA_W];

  // output register holds its value between reads
  always_ff @(posedge r_clk_i) begin
    if (!rst_n_i) begin
      r_data_q <= '0;
    end else if (r_en_i) begin
      r_data_q <= r_byte;
    end
  end

  assign r_data_o = r_data_q;

endmodule

`default_nettype wire

// File: verilog/gray_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gray_sync #(
  parameter int PTR_W       = 3,
  parameter int SYNC_STAGES = 2
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic [PTR_W-1:0] gray_i,
  output logic [PTR_W-1:0] gray_o
);

  logic [PTR_W-1:0] sync_q [SYNC_STAGES];

  // only one bit of gray_i moves per source update, so any sample is
  // either the old or the new pointer
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= gray_i;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign gray_o = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: verilog/gray_ptr_counter.sv
`timescale 1ns/1ps
`default_nettype none

module gray_ptr_counter #(
  parameter int PTR_W = 3
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             en_i,
  output logic [PTR_W-1:0] bin_o,
  output logic [PTR_W-1:0] gray_o
);

  logic [PTR_W-1:0] bin_q;
  logic [PTR_W-1:0] gray_q;
  logic [PTR_W-1:0] bin_nxt;

  // msb is the wrap bit, the rest addresses the memory
  assign bin_nxt = bin_q + 1'b1;

  // gray image kept in a flop so the crossing bus never glitches
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bin_q  <= '0;
      gray_q <= '0;
    end else if (en_i) begin
      bin_q  <= bin_nxt;
      gray_q <= bin_nxt ^ (bin_nxt >> 1);
    end
  end

  assign bin_o  = bin_q;
  assign gray_o = gray_q;

endmodule

`default_nettype wire

// File: verilog/afifo_pkg.sv
`default_nettype none

package afifo_pkg;

  // fixed geometry: 32-bit words in, bytes out, 16 bytes deep
  localparam int AFIFO_W_DATA_W  = 32;
  localparam int AFIFO_R_DATA_W  = 8;
  localparam int AFIFO_RATIO     = AFIFO_W_DATA_W / AFIFO_R_DATA_W;
  localparam int AFIFO_RATIO_LOG = $clog2(AFIFO_RATIO);
  localparam int AFIFO_ADDR_W    = 4;
  localparam int AFIFO_W_ADDR_W  = AFIFO_ADDR_W - AFIFO_RATIO_LOG;
  localparam int AFIFO_DEPTH     = 2 ** AFIFO_ADDR_W;

  typedef logic [AFIFO_W_DATA_W-1:0] wdata_t;
  typedef logic [AFIFO_R_DATA_W-1:0] rdata_t;
  typedef logic [AFIFO_W_ADDR_W-1:0] waddr_t;
  typedef logic [AFIFO_ADDR_W-1:0]   raddr_t;

  // one extra bit so a completely full FIFO reads 16
  typedef logic [AFIFO_ADDR_W:0]     level_t;

  // status seen by either clock domain, level in bytes
  typedef struct packed {
    logic   empty;
    logic   full;
    level_t level;
  } afifo_status_t;

endpackage

`default_nettype wire
